// ==== project.f ====
+incdir+include
rtl/la_pipe_pkg.sv
rtl/la_csr_pkg.sv
rtl/except_judge.sv
rtl/mem_stage.sv
rtl/data_sram.sv
rtl/wb_stage.sv
rtl/csr_file.sv
rtl/mem_subsys_top.sv
tests/tb_mem_subsys.sv

// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -f project.f --top-module tb_mem_subsys -Mdir obj_dir
	./obj_dir/Vtb_mem_subsys | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la_consts.svh"

module tb_mem_subsys
    import la_pipe_pkg::*, la_csr_pkg::*;
();

    // stimulus takes a little over 600 cycles
    localparam int MAX_CYCLES = 1500;
    localparam int MEM_BYTES  = `SRAM_WORDS * `NUM_OF_BYTES;

    typedef enum int {
        T_RESET, T_FILL, T_RANDOM_STORE, T_LOAD_EXTEND, T_STALL, T_EXCEPT_PRIO, T_EXCEPT_INT
    } test_t;

    logic        clk;
    logic        rst;
    logic        stall;
    ex_to_mem_t  ex_info;
    ex_except_t  ex_except;
    csr_wr_t     mem_csr;
    wb_out_t     wb_out;
    mem_except_t mem_except;

    // reference model updated once per clock edge
    logic [7:0]  shadow_mem [MEM_BYTES];
    csr_view_t   shadow_csr;
    csr_wr_t     m_csr;
    logic        m_rw_en;
    reg_addr_t   m_rw_addr;
    lsu_op_t     m_op;
    logic [1:0]  m_off;
    data_t       m_alu;
    data_t       m_word;

    int          errors;
    int          checks;
    int          cycles;
    int          seed;
    addr_t       pc_cnt;
    test_t       test_id;

    mem_subsys_top UUT (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .ex_info    (ex_info),
        .ex_except  (ex_except),
        .mem_csr    (mem_csr),
        .wb_out     (wb_out),
        .mem_except (mem_except)
    );

    always #50 clk = ~clk;

    function automatic data_t fill_word(input int w);
        return data_t'(w) * 32'h9e37_79b1 ^ 32'h5a5a_0000;
    endfunction

    // an access that would cross the word boundary writes nothing
    function automatic byte_mask_t store_mask(input lsu_op_t op, input logic [1:0] off);
        int         size;
        byte_mask_t m;
        size = (op == `ST_B) ? 1 : (op == `ST_H) ? 2 : (op == `ST_W) ? 4 : 0;
        m = '0;
        if (size > 0 && int'(off) + size <= `NUM_OF_BYTES) begin
            for (int i = 0; i < `NUM_OF_BYTES; i++) begin
                if (i >= int'(off) && i < int'(off) + size) begin
                    m[i] = 1'b1;
                end
            end
        end
        return m;
    endfunction

    function automatic data_t load_value(input lsu_op_t op, input logic [1:0] off,
                                         input data_t word, input data_t alu);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * int'(off)));
        h = 16'(word >> (8 * int'(off)));
        case (op)
            `LD_B:   return data_t'(signed'(b));
            `LD_BU:  return data_t'(b);
            `LD_H:   return data_t'(signed'(h));
            `LD_HU:  return data_t'(h);
            `LD_W:   return word;
            default: return alu;
        endcase
    endfunction

    // view of the csrs with a pending write applied
    function automatic csr_view_t forwarded(input csr_view_t v, input csr_wr_t w);
        csr_view_t f;
        f = v;
        if (w.rw_en && w.rw_addr == `CSR_CRMD) begin
            f.crmd = w.rw_data;
        end else if (w.rw_en && w.rw_addr == `CSR_ECFG) begin
            f.ecfg = w.rw_data;
        end else if (w.rw_en && w.rw_addr == `CSR_ESTAT) begin
            f.estat = w.rw_data;
        end else if (w.rw_en && w.rw_addr == `CSR_ERA) begin
            f.era = w.rw_data;
        end
        return f;
    endfunction

    function automatic exc_code_t expected_code(input logic [15:0] flags, input csr_view_t c);
        exc_code_t code;
        code = `EXC_NONE;
        if (c.crmd[2]) begin
            if ((c.estat[12:0] & c.ecfg[12:0]) != 13'h0) begin
                code = `EXC_INT;
            end
        end else begin
            // scan down so the lowest set flag ends up winning
            for (int b = 15; b >= 13; b--) begin
                if (flags[b]) begin
                    code = (b == 13) ? `EXC_INE : (b == 14) ? `EXC_SYS : `EXC_BRK;
                end
            end
        end
        return code;
    endfunction

    function automatic ex_to_mem_t make_pkt(input lsu_op_t op, input addr_t addr,
                                            input data_t data, input logic wr_reg);
        ex_to_mem_t p;
        p.pc        = pc_cnt;
        p.inst      = 32'h0340_0000;
        p.rw_en     = wr_reg;
        p.rw_addr   = reg_addr_t'(pc_cnt[6:2]);
        p.ex_result = addr;
        p.lsu_op    = op;
        p.lsu_data  = data;
        return p;
    endfunction

    task automatic log_mismatch(input string what, input data_t exp_v, input data_t act_v);
        errors++;
        $display("error: %s %s expected %h actual %h", test_id.name(), what, exp_v, act_v);
    endtask

    task automatic drive(input ex_to_mem_t pkt, input logic [15:0] flags,
                         input csr_wr_t csr, input logic stl);
        ex_info         <= pkt;
        ex_except.pc    <= pkt.pc;
        ex_except.flags <= flags;
        mem_csr         <= csr;
        stall           <= stl;
        pc_cnt = pc_cnt + 32'd4;
        @(posedge clk);
    endtask

    task automatic mem_op(input lsu_op_t op, input addr_t addr, input data_t data,
                          input logic wr_reg);
        drive(make_pkt(op, addr, data, wr_reg), 16'h0, '0, 1'b0);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            drive(make_pkt(`LSU_NONE, '0, '0, 1'b0), 16'h0, '0, 1'b0);
        end
    endtask

    task automatic csr_write(input csr_addr_t addr, input data_t data, input logic [15:0] flags);
        csr_wr_t w;
        w.rw_en   = 1'b1;
        w.rw_addr = addr;
        w.rw_data = data;
        drive(make_pkt(`LSU_NONE, '0, '0, 1'b0), flags, w, 1'b0);
    endtask

    task automatic flag_sweep();
        for (int k = 0; k < 8; k++) begin
            drive(make_pkt(`LSU_NONE, '0, '0, 1'b0), {3'(k), 13'h0}, '0, 1'b0);
        end
    endtask

    // checks sample the outputs from before this edge and the model then steps
    always @(posedge clk) begin
        data_t      exp_data;
        exc_code_t  exp_code;
        byte_mask_t mask;
        int         base;
        int         off;
        if (rst) begin
            m_rw_en          = 1'b0;
            m_op             = `LSU_NONE;
            m_word           = '0;
            m_csr            = '0;
            shadow_csr.crmd  = `CSR_CRMD_RST;
            shadow_csr.ecfg  = `CSR_ECFG_RST;
            shadow_csr.estat = `CSR_ESTAT_RST;
            shadow_csr.era   = `CSR_ERA_RST;
        end else begin
            checks++;
            assert (wb_out.rw_en === m_rw_en)
                else log_mismatch("wb_out.rw_en", 32'(m_rw_en), 32'(wb_out.rw_en));
            if (m_rw_en) begin
                exp_data = load_value(m_op, m_off, m_word, m_alu);
                checks += 2;
                assert (wb_out.rw_addr === m_rw_addr)
                    else log_mismatch("wb_out.rw_addr", 32'(m_rw_addr), 32'(wb_out.rw_addr));
                assert (wb_out.rw_data === exp_data)
                    else log_mismatch("wb_out.rw_data", exp_data, wb_out.rw_data);
            end
            exp_code = expected_code(ex_except.flags, forwarded(shadow_csr, m_csr));
            checks += 2;
            assert (mem_except.code === exp_code)
                else log_mismatch("mem_except.code", 32'(exp_code), 32'(mem_except.code));
            assert (mem_except.pc === ex_except.pc)
                else log_mismatch("mem_except.pc", ex_except.pc, mem_except.pc);

            // csr commit happens whether or not stall is high
            shadow_csr = forwarded(shadow_csr, m_csr);
            if (!stall) begin
                base = int'((ex_info.ex_result >> 2) % `SRAM_WORDS) * `NUM_OF_BYTES;
                off  = int'(ex_info.ex_result[1:0]);
                // read sees the word from before this edge
                if (!ex_info.lsu_op[2]) begin
                    m_word = {shadow_mem[base + 3], shadow_mem[base + 2],
                              shadow_mem[base + 1], shadow_mem[base]};
                end
                mask = store_mask(ex_info.lsu_op, ex_info.ex_result[1:0]);
                for (int i = 0; i < `NUM_OF_BYTES; i++) begin
                    if (mask[i]) begin
                        shadow_mem[base + i] = 8'(ex_info.lsu_data >> (8 * (i - off)));
                    end
                end
                m_rw_en   = ex_info.rw_en;
                m_rw_addr = ex_info.rw_addr;
                m_op      = ex_info.lsu_op;
                m_off     = ex_info.ex_result[1:0];
                m_alu     = ex_info.ex_result;
                m_csr     = mem_csr;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not complete within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int      r;
        addr_t   addr;
        addr_t   base;
        data_t   data;
        lsu_op_t op;
        seed    = 32'h06184871;
        errors  = 0;
        checks  = 0;
        cycles  = 0;
        pc_cnt  = 32'h1c00_0000;
        clk     = 1'b0;
        test_id   <= T_RESET;
        rst       <= 1'b1;
        stall     <= 1'b0;
        ex_info   <= '0;
        ex_except <= '0;
        mem_csr   <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        idle(3);

        test_id <= T_FILL;
        for (int w = 0; w < `SRAM_WORDS; w++) begin
            mem_op(`ST_W, addr_t'(w * 4), fill_word(w), 1'b0);
        end

        // misaligned halfword and word stores show up here too
        test_id <= T_RANDOM_STORE;
        for (int k = 0; k < 120; k++) begin
            addr = addr_t'($random(seed));
            data = data_t'($random(seed));
            r    = $unsigned($random(seed)) % 3;
            op   = (r == 0) ? `ST_B : (r == 1) ? `ST_H : `ST_W;
            mem_op(op, addr, data, 1'b0);
            mem_op(`LD_W, addr, '0, 1'b1);
        end

        test_id <= T_LOAD_EXTEND;
        for (int w = 0; w < 4; w++) begin
            data = (w == 0) ? 32'h807f_ff01 : (w == 1) ? 32'h7f80_01fe : data_t'($random(seed));
            base = addr_t'($random(seed)) & ~32'h3;
            mem_op(`ST_W, base, data, 1'b0);
            for (int off = 0; off < 4; off++) begin
                mem_op(`LD_B, base + addr_t'(off), '0, 1'b1);
                mem_op(`LD_BU, base + addr_t'(off), '0, 1'b1);
                if (off < 3) begin
                    mem_op(`LD_H, base + addr_t'(off), '0, 1'b1);
                    mem_op(`LD_HU, base + addr_t'(off), '0, 1'b1);
                end
            end
            mem_op(`LSU_NONE, addr_t'($random(seed)), '0, 1'b1);
        end

        test_id <= T_STALL;
        addr = addr_t'($random(seed)) & ~32'h3;
        mem_op(`LD_W, addr, '0, 1'b1);
        drive(make_pkt(`ST_W, addr, 32'hdead_beef, 1'b1), 16'h0, '0, 1'b1);
        drive(make_pkt(`ST_B, addr + 32'd1, 32'h0000_0011, 1'b1), 16'h0, '0, 1'b1);
        // another word, so a read that slips through the stall shows on wb_out
        drive(make_pkt(`LD_H, addr + 32'd4, '0, 1'b1), 16'h0, '0, 1'b1);
        mem_op(`LD_W, addr, '0, 1'b1);
        idle(2);

        test_id <= T_EXCEPT_PRIO;
        flag_sweep();

        test_id <= T_EXCEPT_INT;
        csr_write(`CSR_ECFG, 32'h0000_0804, 16'h0);
        csr_write(`CSR_ESTAT, 32'h0000_0800, 16'h0);
        // ie becomes visible one cycle later through forwarding
        csr_write(`CSR_CRMD, `CSR_CRMD_RST | 32'h4, 16'h2000);
        flag_sweep();
        csr_write(`CSR_ESTAT, 32'h0, 16'h0);
        idle(2);
        csr_write(`CSR_CRMD, `CSR_CRMD_RST, 16'h0);
        csr_write(`CSR_ERA, data_t'($random(seed)), 16'h0);
        csr_write(14'h3ff, 32'h0000_0004, 16'h0);
        flag_sweep();
        idle(3);

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top
    import la_pipe_pkg::*, la_csr_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       stall,
    input  wire ex_to_mem_t ex_info,
    input  wire ex_except_t ex_except,
    input  wire csr_wr_t    mem_csr,
    output wb_out_t         wb_out,
    output mem_except_t     mem_except
);

    sram_req_t  sram_req;
    data_t      rd_data;
    mem_to_wb_t mem_to_wb;
    csr_wr_t    mem_csr_q;
    csr_wr_t    wb_csr;
    csr_view_t  csr_view;

    mem_stage u_mem_stage (
        .stall       (stall),
        .ex_info     (ex_info),
        .ex_except   (ex_except),
        .mem_csr     (mem_csr),
        .wb_csr      (wb_csr),
        .csr_view    (csr_view),
        .sram_req    (sram_req),
        .mem_to_wb   (mem_to_wb),
        .mem_csr_out (mem_csr_q),
        .mem_except  (mem_except)
    );

    data_sram u_data_sram (
        .clk     (clk),
        .rst     (rst),
        .req     (sram_req),
        .rd_data (rd_data)
    );

    wb_stage u_wb_stage (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .mem_to_wb (mem_to_wb),
        .mem_csr   (mem_csr_q),
        .rd_data   (rd_data),
        .wb_out    (wb_out),
        .wb_csr    (wb_csr)
    );

    csr_file u_csr_file (
        .clk  (clk),
        .rst  (rst),
        .wr   (wb_csr),
        .view (csr_view)
    );

endmodule

`default_nettype wire

// ==== rtl/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la_consts.svh"

module csr_file
    import la_csr_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire csr_wr_t wr,
    output csr_view_t    view
);

    csr_view_t regs;

    always_ff @(posedge clk) begin
        if (rst) begin
            regs.crmd  <= `CSR_CRMD_RST;
            regs.ecfg  <= `CSR_ECFG_RST;
            regs.estat <= `CSR_ESTAT_RST;
            regs.era   <= `CSR_ERA_RST;
        end else if (wr.rw_en) begin
            case (wr.rw_addr)
                `CSR_CRMD:  regs.crmd  <= wr.rw_data;
                `CSR_ECFG:  regs.ecfg  <= wr.rw_data;
                `CSR_ESTAT: regs.estat <= wr.rw_data;
                `CSR_ERA:   regs.era   <= wr.rw_data;
                // unmapped numbers fall through
                default: ;
            endcase
        end
    end

    assign view = regs;

endmodule

`default_nettype wire

// ==== rtl/wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la_consts.svh"

module wb_stage
    import la_pipe_pkg::*, la_csr_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       stall,
    input  wire mem_to_wb_t mem_to_wb,
    input  wire csr_wr_t    mem_csr,
    input  wire data_t      rd_data,
    output wb_out_t         wb_out,
    output csr_wr_t         wb_csr
);

    mem_to_wb_t wb_q;
    csr_wr_t    csr_q;
    data_t      shifted;
    data_t      result;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_q.rw_en  <= 1'b0;
            wb_q.lsu_op <= `LSU_NONE;
            csr_q.rw_en <= 1'b0;
        end else if (!stall) begin
            wb_q  <= mem_to_wb;
            csr_q <= mem_csr;
        end
    end

    // bring the addressed lane down to bit 0
    assign shifted = rd_data >> {wb_q.byte_off, 3'b000};

    always_comb begin
        case (wb_q.lsu_op)
            `LD_B:   result = {{24{shifted[7]}}, shifted[7:0]};
            `LD_BU:  result = {24'h0, shifted[7:0]};
            `LD_H:   result = {{16{shifted[15]}}, shifted[15:0]};
            `LD_HU:  result = {16'h0, shifted[15:0]};
            `LD_W:   result = rd_data;
            default: result = wb_q.alu_result;
        endcase
    end

    assign wb_out.rw_en   = wb_q.rw_en;
    assign wb_out.rw_addr = wb_q.rw_addr;
    assign wb_out.rw_data = result;

    // also the forwarding source for except_judge
    assign wb_csr = csr_q;

endmodule

`default_nettype wire

// ==== rtl/data_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la_consts.svh"

module data_sram
    import la_pipe_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire sram_req_t req,
    output data_t          rd_data
);

    localparam int IDX_W = $clog2(`SRAM_WORDS);

    data_t             mem [`SRAM_WORDS];
    logic [IDX_W-1:0]  idx;

    // low word address bits pick the entry
    assign idx = req.addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (req.wr_en) begin
            for (int i = 0; i < `NUM_OF_BYTES; i++) begin
                if (req.wr_mask[i]) begin
                    mem[idx][i*8 +: 8] <= req.wr_data[i*8 +: 8];
                end
            end
        end
    end

    // read register holds when no read is issued
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else if (req.rd_en) begin
            rd_data <= mem[idx];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la_consts.svh"

module mem_stage
    import la_pipe_pkg::*, la_csr_pkg::*;
(
    input  wire logic        stall,
    input  wire ex_to_mem_t  ex_info,
    input  wire ex_except_t  ex_except,
    input  wire csr_wr_t     mem_csr,
    input  wire csr_wr_t     wb_csr,
    input  wire csr_view_t   csr_view,
    output sram_req_t        sram_req,
    output mem_to_wb_t       mem_to_wb,
    output csr_wr_t          mem_csr_out,
    output mem_except_t      mem_except
);

    logic [1:0] byte_off;
    logic       is_load;
    byte_mask_t st_mask;
    data_t      st_data;

    assign byte_off = ex_info.ex_result[1:0];
    assign is_load  = ~ex_info.lsu_op[2];

    // lane placement, the mask decides what lands
    assign st_data = ex_info.lsu_data << {byte_off, 3'b000};

    always_comb begin
        st_mask = '0;
        case (ex_info.lsu_op)
            `ST_B: begin
                st_mask = 4'b0001 << byte_off;
            end
            `ST_H: begin
                // offset 3 would cross the word
                if (byte_off != 2'b11) begin
                    st_mask = 4'b0011 << byte_off;
                end
            end
            `ST_W: begin
                if (byte_off == 2'b00) begin
                    st_mask = 4'b1111;
                end
            end
            default: begin
                st_mask = '0;
            end
        endcase
    end

    // sram request, word aligned
    assign sram_req.rd_en   = is_load & ~stall;
    assign sram_req.wr_en   = (|st_mask) & ~stall;
    assign sram_req.addr    = {ex_info.ex_result[`ADDR_WIDTH-1:2], 2'b00};
    assign sram_req.wr_data = st_data;
    assign sram_req.wr_mask = st_mask;

    // towards writeback
    assign mem_to_wb.pc         = ex_info.pc;
    assign mem_to_wb.rw_en      = ex_info.rw_en;
    assign mem_to_wb.rw_addr    = ex_info.rw_addr;
    assign mem_to_wb.alu_result = ex_info.ex_result;
    assign mem_to_wb.lsu_op     = ex_info.lsu_op;
    assign mem_to_wb.byte_off   = byte_off;

    assign mem_csr_out = mem_csr;

    except_judge u_except_judge (
        .ex_except  (ex_except),
        .wb_csr     (wb_csr),
        .csr_view   (csr_view),
        .mem_except (mem_except)
    );

endmodule

`default_nettype wire

// ==== rtl/except_judge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la_consts.svh"

module except_judge
    import la_csr_pkg::*;
(
    input  wire ex_except_t  ex_except,
    input  wire csr_wr_t     wb_csr,
    input  wire csr_view_t   csr_view,
    output mem_except_t      mem_except
);

    csr_view_t fwd;
    exc_code_t code;

    // writeback value wins over the csr file when it targets this csr
    function automatic logic [`DATA_WIDTH-1:0] pick(
        input csr_wr_t                wr,
        input csr_addr_t              addr,
        input logic [`DATA_WIDTH-1:0] cur
    );
        if (wr.rw_en && wr.rw_addr == addr) begin
            return wr.rw_data;
        end
        return cur;
    endfunction

    always_comb begin
        fwd.crmd  = pick(wb_csr, `CSR_CRMD,  csr_view.crmd);
        fwd.ecfg  = pick(wb_csr, `CSR_ECFG,  csr_view.ecfg);
        fwd.estat = pick(wb_csr, `CSR_ESTAT, csr_view.estat);
        fwd.era   = pick(wb_csr, `CSR_ERA,   csr_view.era);
    end

    always_comb begin
        code = `EXC_NONE;
        if (fwd.crmd[2]) begin
            // ie set, only pending and enabled interrupts count
            if (|(fwd.estat[12:0] & fwd.ecfg[12:0])) begin
                code = `EXC_INT;
            end
        end else if (ex_except.flags[13]) begin
            code = `EXC_INE;
        end else if (ex_except.flags[14]) begin
            code = `EXC_SYS;
        end else if (ex_except.flags[15]) begin
            code = `EXC_BRK;
        end
    end

    assign mem_except.pc   = ex_except.pc;
    assign mem_except.code = code;

endmodule

`default_nettype wire

// ==== rtl/la_csr_pkg.sv ====
`default_nettype none

`include "la_consts.svh"

package la_csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [5:0]  exc_code_t;

    typedef struct packed {
        logic                  rw_en;
        csr_addr_t             rw_addr;
        logic [`DATA_WIDTH-1:0] rw_data;
    } csr_wr_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] crmd;
        logic [`DATA_WIDTH-1:0] ecfg;
        logic [`DATA_WIDTH-1:0] estat;
        logic [`DATA_WIDTH-1:0] era;
    } csr_view_t;

    // raw flags from decode, bit 13 ine, bit 14 sys, bit 15 brk
    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] pc;
        logic [15:0]            flags;
    } ex_except_t;

    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] pc;
        exc_code_t              code;
    } mem_except_t;

endpackage

`default_nettype wire

// ==== rtl/la_pipe_pkg.sv ====
`default_nettype none

`include "la_consts.svh"

package la_pipe_pkg;

    typedef logic [`DATA_WIDTH-1:0]   data_t;
    typedef logic [`ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`NUM_OF_BYTES-1:0] byte_mask_t;
    typedef logic [3:0]               lsu_op_t;
    typedef logic [4:0]               reg_addr_t;

    // execute stage packet
    typedef struct packed {
        addr_t     pc;
        data_t     inst;
        logic      rw_en;
        reg_addr_t rw_addr;
        data_t     ex_result;
        lsu_op_t   lsu_op;
        data_t     lsu_data;
    } ex_to_mem_t;

    typedef struct packed {
        logic       rd_en;
        logic       wr_en;
        addr_t      addr;
        data_t      wr_data;
        byte_mask_t wr_mask;
    } sram_req_t;

    typedef struct packed {
        addr_t     pc;
        logic      rw_en;
        reg_addr_t rw_addr;
        data_t     alu_result;
        lsu_op_t   lsu_op;
        logic [1:0] byte_off;
    } mem_to_wb_t;

    // goes to the register file write port
    typedef struct packed {
        logic      rw_en;
        reg_addr_t rw_addr;
        data_t     rw_data;
    } wb_out_t;

endpackage

`default_nettype wire

// ==== include/la_consts.svh ====
`ifndef LA_CONSTS_SVH
`define LA_CONSTS_SVH

`define DATA_WIDTH      32
`define ADDR_WIDTH      32
`define NUM_OF_BYTES    4
`define SRAM_WORDS      256

// csr numbers
`define CSR_CRMD        14'h000
`define CSR_ECFG        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006

// crmd comes up in direct address mode with ie clear
`define CSR_CRMD_RST    32'h0000_0008
`define CSR_ECFG_RST    32'h0000_0000
`define CSR_ESTAT_RST   32'h0000_0000
`define CSR_ERA_RST     32'h0000_0000

// lsu opcodes, bit 2 clear means load
`define LD_B            4'b0000
`define LD_H            4'b0001
`define LD_W            4'b0010
`define LD_BU           4'b1000
`define LD_HU           4'b1001
`define ST_B            4'b0100
`define ST_H            4'b0101
`define ST_W            4'b0110
`define LSU_NONE        4'b1111

`define EXC_NONE        6'h3f
`define EXC_INT         6'h00
`define EXC_SYS         6'h0b
`define EXC_BRK         6'h0c
`define EXC_INE         6'h0d

`endif
